//--- common/dm_pkg.sv
/*
 * Debug module package: sizes, CSR addresses, DMI and register structs,
 * command error codes and the decoded CSR access passed between blocks.
 */
package dm_pkg;

  localparam int unsigned NrHarts      = 4;
  localparam int unsigned HartSelLen   = 2;
  localparam int unsigned DataCount    = 2;
  localparam int unsigned ProgBufSize  = 4;
  localparam int unsigned DmiAddrWidth = 7;
  // index widths into the data and program buffer ranges
  localparam int unsigned DataIdxWidth = $clog2(DataCount);
  localparam int unsigned IdxWidth     = $clog2(ProgBufSize);

  localparam logic [3:0] DbgVersion013 = 4'h2;
  localparam logic [1:0] DTM_SUCCESS   = 2'h0;

  typedef enum logic [1:0] {
    DTM_NOP   = 2'h0,
    DTM_READ  = 2'h1,
    DTM_WRITE = 2'h2
  } dtm_op_e;

  typedef enum logic [7:0] {
    Data0      = 8'h04,
    DMControl  = 8'h10,
    DMStatus   = 8'h11,
    AbstractCS = 8'h16,
    Command    = 8'h17,
    ProgBuf0   = 8'h20,
    HaltSum0   = 8'h40
  } dm_csr_e;

  typedef enum logic [2:0] {
    CmdErrNone         = 3'h0,
    CmdErrBusy         = 3'h1,
    CmdErrNotSupported = 3'h2,
    CmdErrorException  = 3'h3,
    CmdErrorHaltResume = 3'h4,
    CmdErrorBus        = 3'h5,
    CmdErrorOther      = 3'h7
  } cmderr_e;

  // bank that answers an address
  typedef enum logic [1:0] {
    RegionNone     = 2'h0,
    RegionCtrl     = 2'h1,
    RegionAbstract = 2'h2
  } csr_region_e;

  // ------------------------------------------------------------------------
  // DMI transport
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [DmiAddrWidth-1:0] addr;
    dtm_op_e                 op;
    logic [31:0]             data;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } dmi_resp_t;

  // ------------------------------------------------------------------------
  // register layouts
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic       haltreq;
    logic       resumereq;
    logic       hartreset;
    logic       ackhavereset;
    logic       zero1;
    logic       hasel;
    logic [9:0] hartsello;
    logic [9:0] hartselhi;
    logic [1:0] zero0;
    logic       setresethaltreq;
    logic       clrresethaltreq;
    logic       ndmreset;
    logic       dmactive;
  } dmcontrol_t;

  typedef struct packed {
    logic [8:0] zero1;
    logic       impebreak;
    logic [1:0] zero0;
    logic       allhavereset;
    logic       anyhavereset;
    logic       allresumeack;
    logic       anyresumeack;
    logic       allnonexistent;
    logic       anynonexistent;
    logic       allunavail;
    logic       anyunavail;
    logic       allrunning;
    logic       anyrunning;
    logic       allhalted;
    logic       anyhalted;
    logic       authenticated;
    logic       authbusy;
    logic       hasresethaltreq;
    logic       confstrptrvalid;
    logic [3:0] version;
  } dmstatus_t;

  typedef struct packed {
    logic [2:0]  zero3;
    logic [4:0]  progbufsize;
    logic [10:0] zero2;
    logic        busy;
    logic        zero1;
    logic [2:0]  cmderr;
    logic [3:0]  zero0;
    logic [3:0]  datacount;
  } abstractcs_t;

  typedef struct packed {
    logic [7:0]  cmdtype;
    logic [23:0] control;
  } command_t;

  // one accepted DMI request, decoded
  typedef struct packed {
    logic                rd;
    logic                wr;
    dm_csr_e             csr;
    logic [IdxWidth-1:0] idx;
    logic [31:0]         wdata;
    csr_region_e         region;
  } csr_access_t;

endpackage : dm_pkg

//--- dmi/dmi_req_decode.sv
/* DMI request decoder: handshake qualification, read and write strobes, address map */
module dmi_req_decode import dm_pkg::*; (
  input  logic        dmi_req_valid_i,
  input  logic        dmi_req_ready_i,
  input  dmi_req_t    dmi_req_i,
  output csr_access_t access_o
);

  logic       accept;
  logic [7:0] addr;

  assign accept = dmi_req_valid_i & dmi_req_ready_i;
  assign addr   = {1'b0, dmi_req_i.addr};

  always_comb begin
    access_o.rd     = accept && (dmi_req_i.op == DTM_READ);
    access_o.wr     = accept && (dmi_req_i.op == DTM_WRITE);
    access_o.wdata  = dmi_req_i.data;
    access_o.csr    = dm_csr_e'(addr);
    access_o.idx    = '0;
    access_o.region = RegionNone;

    // data and progbuf windows collapse onto their base address
    if (addr >= Data0 && addr < Data0 + DataCount) begin
      access_o.csr    = Data0;
      access_o.idx    = IdxWidth'(addr - Data0);
      access_o.region = RegionAbstract;
    end else if (addr >= ProgBuf0 && addr < ProgBuf0 + ProgBufSize) begin
      access_o.csr    = ProgBuf0;
      access_o.idx    = IdxWidth'(addr - ProgBuf0);
      access_o.region = RegionAbstract;
    end else begin
      case (addr)
        DMControl, DMStatus, HaltSum0: begin
          access_o.region = RegionCtrl;
        end
        AbstractCS, Command: begin
          access_o.region = RegionAbstract;
        end
        default: begin
          access_o.region = RegionNone;
        end
      endcase
    end
  end

endmodule : dmi_req_decode

//--- dmi/dmi_resp_queue.sv
/*
 * DMI response queue: picks the read word of the owning bank and holds
 * up to two responses in order
 */
module dmi_resp_queue import dm_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  csr_access_t access_i,
  input  logic        req_valid_i,
  input  logic [31:0] ctrl_rdata_i,
  input  logic [31:0] abs_rdata_i,
  output logic        req_ready_o,
  input  logic        dmi_resp_ready_i,
  output logic        dmi_resp_valid_o,
  output dmi_resp_t   dmi_resp_o
);

  logic [1:0][31:0] resp_data_q;
  logic             rd_ptr_q;
  logic [1:0]       count_q;
  logic             wr_ptr;
  logic             push;
  logic             pop;
  logic [31:0]      resp_word;

  assign req_ready_o      = (count_q != 2'd2);
  assign dmi_resp_valid_o = (count_q != 2'd0);
  assign push             = req_valid_i & req_ready_o;
  assign pop              = dmi_resp_valid_o & dmi_resp_ready_i;
  assign wr_ptr           = rd_ptr_q + count_q[0];

  // writes and unmapped reads answer zero
  always_comb begin
    resp_word = '0;
    if (access_i.rd) begin
      case (access_i.region)
        RegionCtrl:     resp_word = ctrl_rdata_i;
        RegionAbstract: resp_word = abs_rdata_i;
        default:        resp_word = '0;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= 1'b0;
      count_q  <= 2'd0;
    end else begin
      if (pop) begin
        rd_ptr_q <= ~rd_ptr_q;
      end
      count_q <= count_q + 2'(push) - 2'(pop);
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      resp_data_q[wr_ptr] <= resp_word;
    end
  end

  assign dmi_resp_o.data = resp_data_q[rd_ptr_q];
  assign dmi_resp_o.resp = DTM_SUCCESS;

endmodule : dmi_resp_queue

//--- filelist.f
+incdir+tb
common/dm_pkg.sv
dmi/dmi_req_decode.sv
dmi/dmi_resp_queue.sv
rtl/dm_control_regs.sv
rtl/abstract_cmd_regs.sv
rtl/dm_csrs.sv
tb/tb_dm_csrs.sv

//--- rtl/abstract_cmd_regs.sv
/*
 * Abstract command bank: command, cmderr, data and program buffer,
 * with the busy error rules
 */
module abstract_cmd_regs import dm_pkg::*; (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  csr_access_t                 access_i,
  input  logic                        dmactive_i,
  input  logic                        cmdbusy_i,
  input  logic                        cmderror_valid_i,
  input  cmderr_e                     cmderror_i,
  input  logic                        data_valid_i,
  input  logic [DataCount-1:0][31:0]  data_i,
  output logic [31:0]                 rdata_o,
  output logic                        cmd_valid_o,
  output command_t                    cmd_o,
  output logic [DataCount-1:0][31:0]  data_o,
  output logic [ProgBufSize-1:0][31:0] progbuf_o
);

  cmderr_e                      cmderr_d, cmderr_q;
  command_t                     command_d, command_q;
  logic                         cmd_valid_d, cmd_valid_q;
  logic [DataCount-1:0][31:0]   data_d, data_q;
  logic [ProgBufSize-1:0][31:0] progbuf_d, progbuf_q;
  logic [DataIdxWidth-1:0]      data_idx;
  logic                         busy_err;
  abstractcs_t                  abstractcs;
  abstractcs_t                  abstractcs_wr;

  assign data_idx      = access_i.idx[DataIdxWidth-1:0];
  assign abstractcs_wr = abstractcs_t'(access_i.wdata);

  // --------------------------------------------------------------------------
  // next state
  // --------------------------------------------------------------------------
  always_comb begin
    cmderr_d    = cmderr_q;
    command_d   = command_q;
    cmd_valid_d = 1'b0;
    data_d      = data_q;
    progbuf_d   = progbuf_q;
    busy_err    = 1'b0;

    if (access_i.wr) begin
      case (access_i.csr)
        Data0: begin
          if (!cmdbusy_i) data_d[data_idx] = access_i.wdata;
          else            busy_err = 1'b1;
        end
        ProgBuf0: begin
          if (!cmdbusy_i) progbuf_d[access_i.idx] = access_i.wdata;
          else            busy_err = 1'b1;
        end
        AbstractCS: begin
          // write 1 to clear
          if (!cmdbusy_i) cmderr_d = cmderr_e'(~abstractcs_wr.cmderr & cmderr_q);
          else            busy_err = 1'b1;
        end
        Command: begin
          if (!cmdbusy_i) begin
            command_d   = command_t'(access_i.wdata);
            cmd_valid_d = 1'b1;
          end else begin
            busy_err = 1'b1;
          end
        end
        default: ;
      endcase
    end

    if (access_i.rd && cmdbusy_i && (access_i.csr == Data0 || access_i.csr == ProgBuf0)) begin
      busy_err = 1'b1;
    end

    // first error sticks
    if (busy_err && cmderr_q == CmdErrNone) begin
      cmderr_d = CmdErrBusy;
    end
    // hart reported errors win over DMI writes
    if (cmderror_valid_i) begin
      cmderr_d = cmderror_i;
    end
    if (data_valid_i) begin
      data_d = data_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cmderr_q    <= CmdErrNone;
      cmd_valid_q <= 1'b0;
    end else if (!dmactive_i) begin
      cmderr_q    <= CmdErrNone;
      cmd_valid_q <= 1'b0;
    end else begin
      cmderr_q    <= cmderr_d;
      cmd_valid_q <= cmd_valid_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!dmactive_i) begin
      command_q <= '0;
      data_q    <= '0;
      progbuf_q <= '0;
    end else begin
      command_q <= command_d;
      data_q    <= data_d;
      progbuf_q <= progbuf_d;
    end
  end

  // --------------------------------------------------------------------------
  // read word
  // --------------------------------------------------------------------------
  always_comb begin
    abstractcs             = '0;
    abstractcs.datacount   = 4'(DataCount);
    abstractcs.progbufsize = 5'(ProgBufSize);
    abstractcs.busy        = cmdbusy_i;
    abstractcs.cmderr      = cmderr_q;

    // command reads as zero
    case (access_i.csr)
      Data0:      rdata_o = data_q[data_idx];
      ProgBuf0:   rdata_o = progbuf_q[access_i.idx];
      AbstractCS: rdata_o = abstractcs;
      default:    rdata_o = '0;
    endcase
  end

  assign cmd_valid_o = cmd_valid_q;
  assign cmd_o       = command_q;
  assign data_o      = data_q;
  assign progbuf_o   = progbuf_q;

endmodule : abstract_cmd_regs

//--- rtl/dm_control_regs.sv
/*
 * Control bank: dmcontrol, havereset flags, per-hart halt and resume
 * requests, and the dmstatus and haltsum0 read words
 */
module dm_control_regs import dm_pkg::*; (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  csr_access_t           access_i,
  input  logic [NrHarts-1:0]    halted_i,
  input  logic [NrHarts-1:0]    unavailable_i,
  input  logic [NrHarts-1:0]    resumeack_i,
  output logic [31:0]           rdata_o,
  output logic                  dmactive_o,
  output logic                  ndmreset_o,
  output logic [HartSelLen-1:0] hartsel_o,
  output logic [NrHarts-1:0]    haltreq_o,
  output logic [NrHarts-1:0]    resumereq_o,
  output logic                  clear_resumeack_o
);

  dmcontrol_t         dmcontrol_d, dmcontrol_q;
  logic [NrHarts-1:0] havereset_d, havereset_q;
  dmstatus_t          dmstatus;
  logic [31:0]        haltsum0;
  logic               hart_exists;

  assign hartsel_o   = dmcontrol_q.hartsello[HartSelLen-1:0];
  assign hart_exists = (dmcontrol_q.hartsello < NrHarts);
  assign dmactive_o  = dmcontrol_q.dmactive;
  assign ndmreset_o  = dmcontrol_q.ndmreset;

  // --------------------------------------------------------------------------
  // next state
  // --------------------------------------------------------------------------
  always_comb begin
    dmcontrol_d = dmcontrol_q;
    havereset_d = havereset_q;

    if (access_i.wr && access_i.csr == DMControl) begin
      dmcontrol_d = dmcontrol_t'(access_i.wdata);
      // ack applies to the hart named in the same write
      if (dmcontrol_d.ackhavereset && dmcontrol_d.hartsello < NrHarts) begin
        havereset_d[dmcontrol_d.hartsello[HartSelLen-1:0]] = 1'b0;
      end
    end

    // no hart reset, no hart array, no reset-halt support
    dmcontrol_d.hartreset       = 1'b0;
    dmcontrol_d.ackhavereset    = 1'b0;
    dmcontrol_d.zero1           = 1'b0;
    dmcontrol_d.hasel           = 1'b0;
    dmcontrol_d.hartselhi       = '0;
    dmcontrol_d.zero0           = '0;
    dmcontrol_d.setresethaltreq = 1'b0;
    dmcontrol_d.clrresethaltreq = 1'b0;

    clear_resumeack_o = !dmcontrol_q.resumereq && dmcontrol_d.resumereq;

    if (dmcontrol_q.resumereq && resumeack_i[hartsel_o]) begin
      dmcontrol_d.resumereq = 1'b0;
    end

    if (dmcontrol_q.ndmreset) begin
      havereset_d = '1;
    end

    // inactive module: only dmactive may be written
    if (!dmcontrol_q.dmactive) begin
      dmcontrol_d = dmcontrol_t'({31'h0, dmcontrol_d.dmactive});
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      dmcontrol_q <= '0;
      havereset_q <= '1;
    end else begin
      dmcontrol_q <= dmcontrol_d;
      havereset_q <= havereset_d;
    end
  end

  // requests go to the selected hart only
  always_comb begin
    haltreq_o   = '0;
    resumereq_o = '0;
    if (hart_exists) begin
      haltreq_o[hartsel_o]   = dmcontrol_q.haltreq;
      resumereq_o[hartsel_o] = dmcontrol_q.resumereq;
    end
  end

  // --------------------------------------------------------------------------
  // read words
  // --------------------------------------------------------------------------
  always_comb begin
    dmstatus               = '0;
    dmstatus.version       = DbgVersion013;
    dmstatus.authenticated = 1'b1;
    dmstatus.allnonexistent = !hart_exists;
    dmstatus.anynonexistent = !hart_exists;
    if (hart_exists) begin
      dmstatus.allhavereset = havereset_q[hartsel_o];
      dmstatus.anyhavereset = havereset_q[hartsel_o];
      dmstatus.allresumeack = resumeack_i[hartsel_o];
      dmstatus.anyresumeack = resumeack_i[hartsel_o];
      dmstatus.allunavail   = unavailable_i[hartsel_o];
      dmstatus.anyunavail   = unavailable_i[hartsel_o];
      // halted and running are exclusive with unavailable
      dmstatus.allhalted    = halted_i[hartsel_o] & ~unavailable_i[hartsel_o];
      dmstatus.anyhalted    = halted_i[hartsel_o] & ~unavailable_i[hartsel_o];
      dmstatus.allrunning   = ~halted_i[hartsel_o] & ~unavailable_i[hartsel_o];
      dmstatus.anyrunning   = ~halted_i[hartsel_o] & ~unavailable_i[hartsel_o];
    end

    // haltsum0 covers harts hartsel[19:5]*32 and up
    haltsum0 = '0;
    if (dmcontrol_q.hartsello[9:5] == '0) begin
      haltsum0[NrHarts-1:0] = halted_i;
    end

    case (access_i.csr)
      DMControl: rdata_o = dmcontrol_q;
      DMStatus:  rdata_o = dmstatus;
      HaltSum0:  rdata_o = haltsum0;
      default:   rdata_o = '0;
    endcase
  end

endmodule : dm_control_regs

//--- rtl/dm_csrs.sv
/* Debug module register file top: request decode, two register banks, response queue */
module dm_csrs import dm_pkg::*; (
  input  logic                         clk_i,
  input  logic                         rst_ni,
  // DMI
  input  logic                         dmi_req_valid_i,
  output logic                         dmi_req_ready_o,
  input  dmi_req_t                     dmi_req_i,
  output logic                         dmi_resp_valid_o,
  input  logic                         dmi_resp_ready_i,
  output dmi_resp_t                    dmi_resp_o,
  // global control
  output logic                         ndmreset_o,
  output logic                         dmactive_o,
  // hart status and control
  input  logic [NrHarts-1:0]           halted_i,
  input  logic [NrHarts-1:0]           unavailable_i,
  input  logic [NrHarts-1:0]           resumeack_i,
  output logic [HartSelLen-1:0]        hartsel_o,
  output logic [NrHarts-1:0]           haltreq_o,
  output logic [NrHarts-1:0]           resumereq_o,
  output logic                         clear_resumeack_o,
  // abstract commands
  output logic                         cmd_valid_o,
  output command_t                     cmd_o,
  input  logic                         cmderror_valid_i,
  input  cmderr_e                      cmderror_i,
  input  logic                         cmdbusy_i,
  output logic [ProgBufSize-1:0][31:0] progbuf_o,
  output logic [DataCount-1:0][31:0]   data_o,
  input  logic [DataCount-1:0][31:0]   data_i,
  input  logic                         data_valid_i
);

  csr_access_t access;
  logic [31:0] ctrl_rdata;
  logic [31:0] abs_rdata;

  dmi_req_decode i_req_decode (
    .dmi_req_valid_i ( dmi_req_valid_i ),
    .dmi_req_ready_i ( dmi_req_ready_o ),
    .dmi_req_i       ( dmi_req_i       ),
    .access_o        ( access          )
  );

  dm_control_regs i_control_regs (
    .clk_i             ( clk_i             ),
    .rst_ni            ( rst_ni            ),
    .access_i          ( access            ),
    .halted_i          ( halted_i          ),
    .unavailable_i     ( unavailable_i     ),
    .resumeack_i       ( resumeack_i       ),
    .rdata_o           ( ctrl_rdata        ),
    .dmactive_o        ( dmactive_o        ),
    .ndmreset_o        ( ndmreset_o        ),
    .hartsel_o         ( hartsel_o         ),
    .haltreq_o         ( haltreq_o         ),
    .resumereq_o       ( resumereq_o       ),
    .clear_resumeack_o ( clear_resumeack_o )
  );

  abstract_cmd_regs i_abstract_cmd_regs (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .access_i         ( access           ),
    .dmactive_i       ( dmactive_o       ),
    .cmdbusy_i        ( cmdbusy_i        ),
    .cmderror_valid_i ( cmderror_valid_i ),
    .cmderror_i       ( cmderror_i       ),
    .data_valid_i     ( data_valid_i     ),
    .data_i           ( data_i           ),
    .rdata_o          ( abs_rdata        ),
    .cmd_valid_o      ( cmd_valid_o      ),
    .cmd_o            ( cmd_o            ),
    .data_o           ( data_o           ),
    .progbuf_o        ( progbuf_o        )
  );

  dmi_resp_queue i_resp_queue (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .access_i         ( access           ),
    .req_valid_i      ( dmi_req_valid_i  ),
    .ctrl_rdata_i     ( ctrl_rdata       ),
    .abs_rdata_i      ( abs_rdata        ),
    .req_ready_o      ( dmi_req_ready_o  ),
    .dmi_resp_ready_i ( dmi_resp_ready_i ),
    .dmi_resp_valid_o ( dmi_resp_valid_o ),
    .dmi_resp_o       ( dmi_resp_o       )
  );

endmodule : dm_csrs

//--- tb/dm_ref_model.svh
/*
 * Testbench register model: reference copies of the DM registers,
 * expected read words and the queue of expected DMI responses
 */
`ifndef DM_REF_MODEL_SVH
`define DM_REF_MODEL_SVH

  // control bank state
  logic               m_dmactive;
  logic               m_ndmreset;
  logic               m_haltreq;
  logic               m_resumereq;
  logic [9:0]         m_hartsel;
  logic [NrHarts-1:0] m_havereset;
  // abstract bank state
  logic [2:0]         m_cmderr;
  logic [31:0]        m_command;
  logic               m_cmd_valid;
  logic [31:0]        m_data [DataCount];
  logic [31:0]        m_progbuf [ProgBufSize];
  // read data of accepted requests, oldest first
  logic [31:0]        exp_resp_q [$];

  function automatic logic is_data(input logic [6:0] addr);
    return addr == 7'h04 || addr == 7'h05;
  endfunction

  function automatic logic is_progbuf(input logic [6:0] addr);
    return addr[6:2] == 5'h08;
  endfunction

  task automatic model_reset();
    m_dmactive  = 1'b0;
    m_ndmreset  = 1'b0;
    m_haltreq   = 1'b0;
    m_resumereq = 1'b0;
    m_hartsel   = '0;
    m_havereset = '1;
    m_cmderr    = 3'h0;
    m_command   = '0;
    m_cmd_valid = 1'b0;
    m_data      = '{default: '0};
    m_progbuf   = '{default: '0};
    exp_resp_q.delete();
  endtask

  // read word for the current state and the current hart inputs
  function automatic logic [31:0] model_read(input logic [6:0] addr);
    logic [31:0] w;
    logic [1:0]  h;
    logic        h_ok;
    w    = '0;
    h    = m_hartsel[1:0];
    h_ok = (m_hartsel < NrHarts);
    if (is_data(addr)) begin
      w = m_data[addr[0]];
    end else if (is_progbuf(addr)) begin
      w = m_progbuf[addr[1:0]];
    end else begin
      case (addr)
        7'h10: w = {m_haltreq, m_resumereq, 4'h0, m_hartsel, 14'h0, m_ndmreset, m_dmactive};
        7'h11: begin
          w[3:0]   = 4'h2;
          w[7]     = 1'b1;
          w[15:14] = {2{!h_ok}};
          if (h_ok) begin
            w[19:18] = {2{m_havereset[h]}};
            w[17:16] = {2{resumeack_i[h]}};
            w[13:12] = {2{unavailable_i[h]}};
            w[11:10] = {2{!halted_i[h] && !unavailable_i[h]}};
            w[9:8]   = {2{halted_i[h] && !unavailable_i[h]}};
          end
        end
        7'h16: w = {3'h0, 5'(ProgBufSize), 11'h0, cmdbusy_i, 1'b0, m_cmderr, 4'h0,
                    4'(DataCount)};
        7'h40: begin
          if (m_hartsel[9:5] == 5'h0) begin
            w[NrHarts-1:0] = halted_i;
          end
        end
        default: w = '0;
      endcase
    end
    return w;
  endfunction

  // one clock edge of both banks
  task automatic model_clock(input logic wr, input logic rd, input logic [6:0] addr,
                             input logic [31:0] wd);
    logic               n_dmactive;
    logic               n_ndmreset;
    logic               n_haltreq;
    logic               n_resumereq;
    logic [9:0]         n_hartsel;
    logic [NrHarts-1:0] n_havereset;
    logic [2:0]         n_cmderr;
    logic               busy_err;
    int                 i;

    // abstract bank first, it sees the old dmactive
    n_cmderr    = m_cmderr;
    busy_err    = 1'b0;
    m_cmd_valid = 1'b0;
    if (!m_dmactive) begin
      n_cmderr  = 3'h0;
      m_command = '0;
      m_data    = '{default: '0};
      m_progbuf = '{default: '0};
    end else begin
      if (wr && (is_data(addr) || is_progbuf(addr) || addr == 7'h16 || addr == 7'h17)) begin
        if (cmdbusy_i) begin
          busy_err = 1'b1;
        end else if (is_data(addr)) begin
          m_data[addr[0]] = wd;
        end else if (is_progbuf(addr)) begin
          m_progbuf[addr[1:0]] = wd;
        end else if (addr == 7'h16) begin
          n_cmderr = m_cmderr & ~wd[10:8];
        end else begin
          m_command   = wd;
          m_cmd_valid = 1'b1;
        end
      end
      if (rd && cmdbusy_i && (is_data(addr) || is_progbuf(addr))) begin
        busy_err = 1'b1;
      end
      if (busy_err && m_cmderr == 3'h0) begin
        n_cmderr = 3'h1;
      end
      if (cmderror_valid_i) begin
        n_cmderr = cmderror_i;
      end
      if (data_valid_i) begin
        for (i = 0; i < DataCount; i++) begin
          m_data[i] = data_i[i];
        end
      end
    end
    m_cmderr = n_cmderr;

    // ------------------------------------------------------------------------
    // control bank
    // ------------------------------------------------------------------------
    n_dmactive  = m_dmactive;
    n_ndmreset  = m_ndmreset;
    n_haltreq   = m_haltreq;
    n_resumereq = m_resumereq;
    n_hartsel   = m_hartsel;
    n_havereset = m_havereset;
    if (wr && addr == 7'h10) begin
      n_haltreq   = wd[31];
      n_resumereq = wd[30];
      n_hartsel   = wd[25:16];
      n_ndmreset  = wd[1];
      n_dmactive  = wd[0];
      if (wd[28] && wd[25:16] < NrHarts) begin
        n_havereset[wd[17:16]] = 1'b0;
      end
    end
    if (m_resumereq && resumeack_i[m_hartsel[1:0]]) begin
      n_resumereq = 1'b0;
    end
    if (m_ndmreset) begin
      n_havereset = '1;
    end
    if (!m_dmactive) begin
      n_ndmreset  = 1'b0;
      n_haltreq   = 1'b0;
      n_resumereq = 1'b0;
      n_hartsel   = '0;
    end
    m_dmactive  = n_dmactive;
    m_ndmreset  = n_ndmreset;
    m_haltreq   = n_haltreq;
    m_resumereq = n_resumereq;
    m_hartsel   = n_hartsel;
    m_havereset = n_havereset;
  endtask

`endif

//--- tb/tb_dm_csrs.sv
/*
 * Testbench for the debug module register file: random DMI traffic,
 * random hart stub, reference model checks and a watchdog
 */
module tb_dm_csrs import dm_pkg::*; ();

  timeunit 1ns;
  timeprecision 100ps;

  localparam int unsigned NumTxn      = 3000;
  localparam int unsigned ClkPeriod   = 10;
  localparam int unsigned ResetCycles = 16;
  localparam logic [31:0] Seed        = 32'h2811_6345;

  logic                         clk_i;
  logic                         rst_ni;
  logic                         dmi_req_valid_i;
  logic                         dmi_req_ready_o;
  dmi_req_t                     dmi_req_i;
  logic                         dmi_resp_valid_o;
  logic                         dmi_resp_ready_i;
  dmi_resp_t                    dmi_resp_o;
  logic                         ndmreset_o;
  logic                         dmactive_o;
  logic [NrHarts-1:0]           halted_i;
  logic [NrHarts-1:0]           unavailable_i;
  logic [NrHarts-1:0]           resumeack_i;
  logic [HartSelLen-1:0]        hartsel_o;
  logic [NrHarts-1:0]           haltreq_o;
  logic [NrHarts-1:0]           resumereq_o;
  logic                         clear_resumeack_o;
  logic                         cmd_valid_o;
  command_t                     cmd_o;
  logic                         cmderror_valid_i;
  cmderr_e                      cmderror_i;
  logic                         cmdbusy_i;
  logic [ProgBufSize-1:0][31:0] progbuf_o;
  logic [DataCount-1:0][31:0]   data_o;
  logic [DataCount-1:0][31:0]   data_i;
  logic                         data_valid_i;
  int                           num_sent;
  int                           num_accepted;

  `include "dm_ref_model.svh"

  dm_csrs dm_csrs_i (.*);

  always #(ClkPeriod / 2) clk_i = ~clk_i;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got === exp) else begin
      abort_run($sformatf("ERR %s got 0x%08h expected 0x%08h at %0t", name, got, exp, $time));
    end
  endtask

  // outputs that follow directly from the model state
  task automatic check_outputs();
    logic [NrHarts-1:0] exp_halt;
    logic [NrHarts-1:0] exp_resume;
    logic               exp_clear;
    int                 i;
    exp_halt   = '0;
    exp_resume = '0;
    if (m_hartsel < NrHarts) begin
      exp_halt[m_hartsel[1:0]]   = m_haltreq;
      exp_resume[m_hartsel[1:0]] = m_resumereq;
    end
    exp_clear = dmi_req_valid_i && dmi_req_ready_o && dmi_req_i.op == DTM_WRITE &&
                dmi_req_i.addr == 7'h10 && dmi_req_i.data[30] && !m_resumereq;
    check_value("dmi_req_ready_o", 32'(dmi_req_ready_o), 32'(exp_resp_q.size() < 2));
    check_value("dmi_resp_valid_o", 32'(dmi_resp_valid_o), 32'(exp_resp_q.size() != 0));
    check_value("dmactive_o", 32'(dmactive_o), 32'(m_dmactive));
    check_value("ndmreset_o", 32'(ndmreset_o), 32'(m_ndmreset));
    check_value("hartsel_o", 32'(hartsel_o), 32'(m_hartsel[1:0]));
    check_value("haltreq_o", 32'(haltreq_o), 32'(exp_halt));
    check_value("resumereq_o", 32'(resumereq_o), 32'(exp_resume));
    check_value("clear_resumeack_o", 32'(clear_resumeack_o), 32'(exp_clear));
    check_value("cmd_valid_o", 32'(cmd_valid_o), 32'(m_cmd_valid));
    check_value("cmd_o", cmd_o, m_command);
    for (i = 0; i < DataCount; i++) begin
      check_value($sformatf("data_o[%0d]", i), data_o[i], m_data[i]);
    end
    for (i = 0; i < ProgBufSize; i++) begin
      check_value($sformatf("progbuf_o[%0d]", i), progbuf_o[i], m_progbuf[i]);
    end
  endtask

  // random DMI request, biased to mapped CSRs
  task automatic drive_request();
    logic [3:0]  pick;
    logic [6:0]  addr;
    logic [31:0] wdata;
    dtm_op_e     op;
    // a pending request holds until accepted
    if (!dmi_req_valid_i || dmi_req_ready_o) begin
      if (num_sent < NumTxn && $urandom % 4 != 0) begin
        pick = 4'($urandom);
        case (pick)
          0, 1, 2:    addr = 7'h04 + 7'($urandom % 2);
          3, 4, 5:    addr = 7'h10;
          6, 7:       addr = 7'h11;
          8, 9:       addr = 7'h16;
          10, 11:     addr = 7'h17;
          12, 13:     addr = 7'h20 + 7'($urandom % 4);
          14:         addr = 7'h40;
          default:    addr = 7'($urandom);
        endcase
        wdata = $urandom;
        if (addr == 7'h10) begin
          wdata[0]     = ($urandom % 8 != 0);
          wdata[1]     = ($urandom % 8 == 0);
          wdata[25:16] = ($urandom % 8 == 0) ? 10'($urandom) : 10'($urandom % 5);
        end
        pick = 4'($urandom % 10);
        op   = (pick == 0) ? DTM_NOP : (pick < 6) ? DTM_READ : DTM_WRITE;
        dmi_req_valid_i <= 1'b1;
        dmi_req_i.addr  <= addr;
        dmi_req_i.op    <= op;
        dmi_req_i.data  <= wdata;
        num_sent++;
      end else begin
        dmi_req_valid_i <= 1'b0;
      end
    end
  endtask

  // hart stub and response back-pressure
  task automatic drive_hart_inputs();
    logic [2:0] err;
    err = 3'($urandom % 8);
    if (err == 3'h6) begin
      err = 3'h7;
    end
    halted_i         <= NrHarts'($urandom);
    unavailable_i    <= NrHarts'($urandom);
    resumeack_i      <= NrHarts'($urandom);
    cmdbusy_i        <= ($urandom % 4 == 0);
    cmderror_valid_i <= ($urandom % 16 == 0);
    cmderror_i       <= cmderr_e'(err);
    data_valid_i     <= ($urandom % 16 == 0);
    data_i           <= {$urandom, $urandom};
    dmi_resp_ready_i <= ($urandom % 3 != 0);
  endtask

  // --------------------------------------------------------------------------
  // per-cycle model update, checks and stimulus
  // --------------------------------------------------------------------------
  always @(posedge clk_i) begin : check_and_drive
    logic accepted;
    if (rst_ni) begin
      check_outputs();
      if (dmi_resp_valid_o && dmi_resp_ready_i) begin
        check_value("dmi_resp_o.resp", 32'(dmi_resp_o.resp), 32'h0);
        check_value("dmi_resp_o.data", dmi_resp_o.data, exp_resp_q.pop_front());
      end
      accepted = dmi_req_valid_i && dmi_req_ready_o;
      if (accepted) begin
        exp_resp_q.push_back((dmi_req_i.op == DTM_READ) ? model_read(dmi_req_i.addr) : '0);
        num_accepted++;
      end
      model_clock(accepted && dmi_req_i.op == DTM_WRITE, accepted && dmi_req_i.op == DTM_READ,
                  dmi_req_i.addr, dmi_req_i.data);
      drive_request();
      drive_hart_inputs();
    end
  end

  initial begin
    void'($urandom(Seed));
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    dmi_req_valid_i  = 1'b0;
    dmi_req_i        = '0;
    dmi_resp_ready_i = 1'b0;
    halted_i         = '0;
    unavailable_i    = '0;
    resumeack_i      = '0;
    cmderror_valid_i = 1'b0;
    cmderror_i       = CmdErrNone;
    cmdbusy_i        = 1'b0;
    data_i           = '0;
    data_valid_i     = 1'b0;
    num_sent         = 0;
    num_accepted     = 0;
    model_reset();
    repeat (ResetCycles) @(posedge clk_i);
    rst_ni <= 1'b1;
    wait (num_accepted == NumTxn);
    // drain the response queue
    @(posedge clk_i);
    while (dmi_resp_valid_o) begin
      @(posedge clk_i);
    end
    if (exp_resp_q.size() == 0) begin
      $display("Testbench passed");
      $finish;
    end else begin
      abort_run("responses missing after the response queue drained");
    end
  end

  initial begin
    #((ResetCycles + NumTxn * 20) * ClkPeriod);
    abort_run("watchdog timeout: DMI traffic did not complete in time");
  end

endmodule : tb_dm_csrs
